// File: rtl/taint_pkg.sv
`default_nettype none

package taint_pkg;

    // operation codes shared by dispatch and lanes
    typedef enum logic [2:0] {
        op_and = 3'd0,
        op_or  = 3'd1,
        op_xor = 3'd2,
        op_add = 3'd3,
        op_sub = 3'd4,
        op_shl = 3'd5,
        op_shr = 3'd6
    } op_e;

    // default array shape
    localparam int DEF_LANES     = 4;
    localparam int DEF_WIDTH     = 8;
    localparam int DEF_ADDR_BITS = 3;

    // derived sizes for the default shape
    localparam int DEF_ROW_BITS = DEF_LANES * DEF_WIDTH;
    localparam int DEF_ROWS     = 2 ** DEF_ADDR_BITS;

    // one table row: the taint of every lane of one result, lane 0 in the low bits
    typedef logic [DEF_ROW_BITS-1:0] row_t;

endpackage

`default_nettype wire

// File: rtl/operand_if.sv
`timescale 1ns/100ps
`default_nettype none

interface operand_if #(
    parameter int WIDTH = 8
);
    import taint_pkg::*;

    // strobe and its taint
    logic             valid;
    logic             valid_taint;
    op_e              op;

    // operand words with their taint masks
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] a_taint;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] b_taint;

    modport src (
        output valid, valid_taint, op,
        output a, a_taint, b, b_taint
    );

    modport dst (
        input valid, valid_taint, op,
        input a, a_taint, b, b_taint
    );

endinterface

`default_nettype wire

// File: rtl/operand_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module operand_dispatch #(
    parameter int LANES     = 4,
    parameter int WIDTH     = 8,
    parameter int ADDR_BITS = 3
) (
    input  wire                      pos_clk,
    input  wire                      pos_arst,
    input  wire                      in_valid,
    input  wire                      in_valid_taint,
    input  taint_pkg::op_e           op,
    input  wire [LANES*WIDTH-1:0]    a_data,
    input  wire [LANES*WIDTH-1:0]    a_taint,
    input  wire [LANES*WIDTH-1:0]    b_data,
    input  wire [LANES*WIDTH-1:0]    b_taint,
    input  wire [ADDR_BITS-1:0]      wr_addr,
    input  wire [ADDR_BITS-1:0]      wr_addr_taint,
    operand_if.src                   lane_if [LANES],
    output logic                     st_valid,
    output logic [ADDR_BITS-1:0]     st_addr,
    output logic [ADDR_BITS-1:0]     st_addr_taint
);
    import taint_pkg::*;

    logic                   st_valid_taint;
    op_e                    op_q;
    logic [LANES*WIDTH-1:0] a_q;
    logic [LANES*WIDTH-1:0] at_q;
    logic [LANES*WIDTH-1:0] b_q;
    logic [LANES*WIDTH-1:0] bt_q;

    // strobes must come out of reset low
    always_ff @(posedge pos_clk, posedge pos_arst) begin
        if (pos_arst) begin
            st_valid       <= 1'b0;
            st_valid_taint <= 1'b0;
        end else begin
            st_valid       <= in_valid;
            st_valid_taint <= in_valid_taint;
        end
    end

    // operands and address travel together, every cycle
    always_ff @(posedge pos_clk) begin
        op_q          <= op;
        a_q           <= a_data;
        at_q          <= a_taint;
        b_q           <= b_data;
        bt_q          <= b_taint;
        st_addr       <= wr_addr;
        st_addr_taint <= wr_addr_taint;
    end

    // split the wide buses into one operand set per lane
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        assign lane_if[g].valid       = st_valid;
        assign lane_if[g].valid_taint = st_valid_taint;
        assign lane_if[g].op          = op_q;
        assign lane_if[g].a           = a_q[g*WIDTH +: WIDTH];
        assign lane_if[g].a_taint     = at_q[g*WIDTH +: WIDTH];
        assign lane_if[g].b           = b_q[g*WIDTH +: WIDTH];
        assign lane_if[g].b_taint     = bt_q[g*WIDTH +: WIDTH];
    end

endmodule

`default_nettype wire

// File: rtl/taint_lane.sv
`timescale 1ns/100ps
`default_nettype none

module taint_lane #(
    parameter int WIDTH = 8
) (
    input  wire              pos_clk,
    input  wire              pos_arst,
    operand_if.dst           opnd,
    output logic             res_valid,
    output logic [WIDTH-1:0] res_data,
    output logic [WIDTH-1:0] res_taint
);
    import taint_pkg::*;

    // enough shift bits to cover the word
    localparam int SH_BITS = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [SH_BITS-1:0] shamt;
    logic [WIDTH-1:0]   a_lo;
    logic [WIDTH-1:0]   a_hi;
    logic [WIDTH-1:0]   b_lo;
    logic [WIDTH-1:0]   b_hi;
    logic [WIDTH-1:0]   arith_taint;
    logic               any_taint;
    logic [WIDTH-1:0]   nxt_data;
    logic [WIDTH-1:0]   nxt_taint;
    logic [WIDTH-1:0]   en_diff;

    assign shamt = opnd.b[SH_BITS-1:0];

    // tainted bits forced low and forced high
    assign a_lo = opnd.a & ~opnd.a_taint;
    assign a_hi = opnd.a | opnd.a_taint;
    assign b_lo = opnd.b & ~opnd.b_taint;
    assign b_hi = opnd.b | opnd.b_taint;

    assign any_taint = |{opnd.a_taint, opnd.b_taint};

    // carry chain taint: bits where the two extreme results disagree
    always_comb begin
        if (opnd.op == op_sub) begin
            arith_taint = (a_lo - b_lo) ^ (a_hi - b_hi);
        end else begin
            arith_taint = (a_lo + b_lo) ^ (a_hi + b_hi);
        end
        arith_taint = arith_taint | opnd.a_taint | opnd.b_taint;
    end

    always_comb begin
        case (opnd.op)
            op_and: begin
                nxt_data  = opnd.a & opnd.b;
                nxt_taint = (opnd.a_taint & opnd.b) | (opnd.b_taint & opnd.a)
                          | (opnd.a_taint & opnd.b_taint);
            end
            op_or: begin
                nxt_data  = opnd.a | opnd.b;
                nxt_taint = (opnd.a_taint & ~opnd.b) | (opnd.b_taint & ~opnd.a)
                          | (opnd.a_taint & opnd.b_taint);
            end
            op_add: begin
                nxt_data  = opnd.a + opnd.b;
                nxt_taint = arith_taint;
            end
            op_sub: begin
                nxt_data  = opnd.a - opnd.b;
                nxt_taint = arith_taint;
            end
            op_shl: begin
                nxt_data  = opnd.a << shamt;
                nxt_taint = (|opnd.b_taint) ? {WIDTH{1'b1}} : opnd.a_taint << shamt;
            end
            op_shr: begin
                nxt_data  = opnd.a >> shamt;
                nxt_taint = (|opnd.b_taint) ? {WIDTH{1'b1}} : opnd.a_taint >> shamt;
            end
            default: begin
                // xor: any tainted input taints the word
                nxt_data  = opnd.a ^ opnd.b;
                nxt_taint = {WIDTH{any_taint}};
            end
        endcase
    end

    // bits that would flip if the enable went the other way
    assign en_diff = nxt_data ^ res_data;

    always_ff @(posedge pos_clk, posedge pos_arst) begin
        if (pos_arst) begin
            res_valid <= 1'b0;
            res_data  <= '0;
            res_taint <= '0;
        end else begin
            res_valid <= opnd.valid;
            if (opnd.valid) begin
                res_data  <= nxt_data;
                res_taint <= opnd.valid_taint ? (nxt_taint | en_diff) : nxt_taint;
            end else if (opnd.valid_taint) begin
                // data held, taint grows
                res_taint <= res_taint | en_diff;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/taint_table.sv
`timescale 1ns/100ps
`default_nettype none

module taint_table #(
    parameter int LANES     = 4,
    parameter int WIDTH     = 8,
    parameter int ADDR_BITS = 3
) (
    input  wire                      pos_clk,
    input  wire                      pos_arst,
    input  wire                      st_valid,
    input  wire  [ADDR_BITS-1:0]     st_addr,
    input  wire  [ADDR_BITS-1:0]     st_addr_taint,
    input  wire  [LANES*WIDTH-1:0]   row_taint,
    input  wire  [ADDR_BITS-1:0]     rd_addr,
    input  wire  [ADDR_BITS-1:0]     rd_addr_taint,
    output logic [LANES*WIDTH-1:0]   rd_taint,
    output logic [ADDR_BITS:0]       taint_count
);
    localparam int ROW_BITS = LANES * WIDTH;
    localparam int ROWS     = 2 ** ADDR_BITS;

    logic [ROW_BITS-1:0]  rows [ROWS];
    logic                 wr_valid_q;
    logic [ADDR_BITS-1:0] wr_addr_q;
    logic [ADDR_BITS-1:0] wr_addr_taint_q;
    logic [ROW_BITS-1:0]  wr_row;
    logic                 old_hit;
    logic                 new_hit;

    // one more stage so the address lines up with the lane registers
    always_ff @(posedge pos_clk, posedge pos_arst) begin
        if (pos_arst) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= st_valid;
        end
    end

    always_ff @(posedge pos_clk) begin
        wr_addr_q       <= st_addr;
        wr_addr_taint_q <= st_addr_taint;
    end

    // a tainted address could have hit this row with anything
    assign wr_row  = (|wr_addr_taint_q) ? {ROW_BITS{1'b1}} : row_taint;
    assign old_hit = |rows[wr_addr_q];
    assign new_hit = |wr_row;

    always_ff @(posedge pos_clk, posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < ROWS; i++) begin
                rows[i] <= '0;
            end
            taint_count <= '0;
        end else if (wr_valid_q) begin
            rows[wr_addr_q] <= wr_row;
            // count only clean <-> tainted transitions
            if (!old_hit && new_hit) begin
                taint_count <= taint_count + 1'b1;
            end else if (old_hit && !new_hit) begin
                taint_count <= taint_count - 1'b1;
            end
        end
    end

    // async read, tainted address poisons the whole row
    assign rd_taint = (|rd_addr_taint) ? {ROW_BITS{1'b1}} : rows[rd_addr];

endmodule

`default_nettype wire

// File: rtl/taint_alu_array.sv
`timescale 1ns/100ps
`default_nettype none

module taint_alu_array #(
    parameter int LANES     = taint_pkg::DEF_LANES,
    parameter int WIDTH     = taint_pkg::DEF_WIDTH,
    parameter int ADDR_BITS = taint_pkg::DEF_ADDR_BITS
) (
    input  wire                      pos_clk,
    input  wire                      pos_arst,
    input  wire                      in_valid,
    input  wire                      in_valid_taint,
    input  taint_pkg::op_e           op,
    input  wire [LANES*WIDTH-1:0]    a_data,
    input  wire [LANES*WIDTH-1:0]    a_taint,
    input  wire [LANES*WIDTH-1:0]    b_data,
    input  wire [LANES*WIDTH-1:0]    b_taint,
    input  wire [ADDR_BITS-1:0]      wr_addr,
    input  wire [ADDR_BITS-1:0]      wr_addr_taint,
    input  wire [ADDR_BITS-1:0]      rd_addr,
    input  wire [ADDR_BITS-1:0]      rd_addr_taint,
    output wire                      out_valid,
    output wire [LANES*WIDTH-1:0]    res_data,
    output wire [LANES*WIDTH-1:0]    res_taint,
    output wire [LANES*WIDTH-1:0]    rd_taint,
    output wire [ADDR_BITS:0]        taint_count
);
    wire                 st_valid;
    wire [ADDR_BITS-1:0] st_addr;
    wire [ADDR_BITS-1:0] st_addr_taint;
    wire [LANES-1:0]     lane_valid;

    operand_if #(.WIDTH(WIDTH)) lane_if [LANES] ();

    operand_dispatch #(
        .LANES     (LANES),
        .WIDTH     (WIDTH),
        .ADDR_BITS (ADDR_BITS)
    ) i_operand_dispatch (
        .pos_clk        (pos_clk),
        .pos_arst       (pos_arst),
        .in_valid       (in_valid),
        .in_valid_taint (in_valid_taint),
        .op             (op),
        .a_data         (a_data),
        .a_taint        (a_taint),
        .b_data         (b_data),
        .b_taint        (b_taint),
        .wr_addr        (wr_addr),
        .wr_addr_taint  (wr_addr_taint),
        .lane_if        (lane_if),
        .st_valid       (st_valid),
        .st_addr        (st_addr),
        .st_addr_taint  (st_addr_taint)
    );

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        taint_lane #(.WIDTH(WIDTH)) i_taint_lane (
            .pos_clk   (pos_clk),
            .pos_arst  (pos_arst),
            .opnd      (lane_if[g]),
            .res_valid (lane_valid[g]),
            .res_data  (res_data[g*WIDTH +: WIDTH]),
            .res_taint (res_taint[g*WIDTH +: WIDTH])
        );
    end

    // all lanes run in lockstep
    assign out_valid = lane_valid[0];

    // the lane taints form one table row
    taint_table #(
        .LANES     (LANES),
        .WIDTH     (WIDTH),
        .ADDR_BITS (ADDR_BITS)
    ) i_taint_table (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .st_valid      (st_valid),
        .st_addr       (st_addr),
        .st_addr_taint (st_addr_taint),
        .row_taint     (res_taint),
        .rd_addr       (rd_addr),
        .rd_addr_taint (rd_addr_taint),
        .rd_taint      (rd_taint),
        .taint_count   (taint_count)
    );

endmodule

`default_nettype wire

// File: test/taint_alu_array_assert.sv
`timescale 1ns/100ps
`default_nettype none

module taint_alu_array_assert #(
    parameter int ADDR_BITS = 3
) (
    input wire               pos_clk,
    input wire               pos_arst,
    input wire               in_valid,
    input wire               out_valid,
    input wire [ADDR_BITS:0] taint_count
);
    int fail_count = 0;

    // nothing pending when reset lets go
    a_quiet_after_reset: assert property (@(posedge pos_clk) pos_arst |=> !out_valid)
        else begin
            $error("out_valid high on the cycle after reset");
            fail_count++;
        end

    // dispatch stage plus lane stage
    a_two_cycle_latency: assert property (@(posedge pos_clk) disable iff (pos_arst)
        out_valid == $past(in_valid, 2))
        else begin
            $error("out_valid does not follow in_valid by two cycles");
            fail_count++;
        end

    a_count_bound: assert property (@(posedge pos_clk) disable iff (pos_arst)
        int'(taint_count) <= 2 ** ADDR_BITS)
        else begin
            $error("taint_count above the number of rows");
            fail_count++;
        end

endmodule

bind taint_alu_array taint_alu_array_assert #(.ADDR_BITS(ADDR_BITS)) i_taint_alu_array_assert (
    .pos_clk     (pos_clk),
    .pos_arst    (pos_arst),
    .in_valid    (in_valid),
    .out_valid   (out_valid),
    .taint_count (taint_count)
);

`default_nettype wire

// File: test/tb_taint_alu_array.sv
`timescale 1ns/100ps
`default_nettype none

module tb_taint_alu_array;
    import taint_pkg::*;

    localparam int L  = DEF_LANES;
    localparam int W  = DEF_WIDTH;
    localparam int AB = DEF_ADDR_BITS;
    localparam int RB = L * W;
    localparam int SH = $clog2(W);
    // six tests of 64 cycles plus reset come to about 400 cycles
    localparam int MAX_CYCLES = 2000;

    logic          pos_clk;
    logic          pos_arst;
    logic          in_valid;
    logic          in_valid_taint;
    op_e           op;
    logic [RB-1:0] a_data, a_taint, b_data, b_taint;
    logic [AB-1:0] wr_addr, wr_addr_taint, rd_addr, rd_addr_taint;
    wire           out_valid;
    wire  [RB-1:0] res_data, res_taint, rd_taint;
    wire  [AB:0]   taint_count;

    logic [31:0]   seed = 32'h52bb_854d;
    int            errors = 0;
    int            checks = 0;
    int            cycles = 0;
    string         test_names [6] = '{"plain ops", "and/or masking", "carry chain",
                                      "shifts", "table rows", "enable taint"};

    // model pipeline: d_ is the dispatch stage, t_ the table address stage
    logic          d_valid, d_vt, t_valid, m_valid;
    op_e           d_op;
    logic [RB-1:0] d_a, d_at, d_b, d_bt, m_data, m_taint;
    logic [AB-1:0] d_addr, d_addr_taint, t_addr, t_addr_taint;
    logic [RB-1:0] m_rows [2**AB];

    taint_alu_array i_taint_alu_array (.*);

    initial begin
        pos_clk = 1'b0;
        forever #20 pos_clk = ~pos_clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [RB-1:0] rand_bus();
        logic [RB-1:0] v;
        logic [31:0]   r;
        for (int i = 0; i < RB; i++) begin
            if (i % 32 == 0) r = next_rand();
            v[i] = r[i % 32];
        end
        return v;
    endfunction

    // one tainted bit per lane, position taken from bits of r
    function automatic logic [RB-1:0] bit_per_lane(input logic [31:0] r, input int bits);
        logic [RB-1:0] v;
        int            pos;
        v = '0;
        for (int l = 0; l < L; l++) begin
            pos = int'((r >> (l * bits)) & ((32'd1 << bits) - 32'd1));
            v[l * W + pos] = 1'b1;
        end
        return v;
    endfunction

    // expected {data, taint} of one lane
    function automatic logic [2*W-1:0] lane_ref(input op_e o, input logic [W-1:0] a,
            input logic [W-1:0] at, input logic [W-1:0] b, input logic [W-1:0] bt);
        logic [W-1:0]  d;
        logic [W-1:0]  t;
        logic [SH-1:0] sh;
        sh = b[SH-1:0];
        case (o)
            op_and: begin
                d = a & b;
                t = (at & b) | (bt & a) | (at & bt);
            end
            op_or: begin
                d = a | b;
                t = (at & ~b) | (bt & ~a) | (at & bt);
            end
            op_add: begin
                d = a + b;
                t = ((a & ~at) + (b & ~bt)) ^ ((a | at) + (b | bt)) | at | bt;
            end
            op_sub: begin
                d = a - b;
                t = ((a & ~at) - (b & ~bt)) ^ ((a | at) - (b | bt)) | at | bt;
            end
            op_shl: begin
                d = a << sh;
                t = (bt != '0) ? '1 : at << sh;
            end
            op_shr: begin
                d = a >> sh;
                t = (bt != '0) ? '1 : at >> sh;
            end
            default: begin
                d = a ^ b;
                t = ((at | bt) != '0) ? '1 : '0;
            end
        endcase
        return {d, t};
    endfunction

    function automatic logic [AB:0] count_tainted_rows();
        int n;
        n = 0;
        for (int i = 0; i < 2**AB; i++) begin
            if (m_rows[i] != '0) n++;
        end
        return n[AB:0];
    endfunction

    // model state advances on the same edges as the DUT registers
    always @(posedge pos_clk or posedge pos_arst) begin : model_step
        logic [2*W-1:0] r;
        logic [W-1:0]   old;
        if (pos_arst) begin
            d_valid = 1'b0;
            d_vt    = 1'b0;
            t_valid = 1'b0;
            m_valid = 1'b0;
            m_data  = '0;
            m_taint = '0;
            for (int i = 0; i < 2**AB; i++) m_rows[i] = '0;
        end else begin
            // table sees the lane taint from before this edge
            if (t_valid) m_rows[t_addr] = (t_addr_taint != '0) ? '1 : m_taint;
            t_valid      = d_valid;
            t_addr       = d_addr;
            t_addr_taint = d_addr_taint;
            m_valid      = d_valid;
            for (int l = 0; l < L; l++) begin
                r   = lane_ref(d_op, d_a[l*W +: W], d_at[l*W +: W], d_b[l*W +: W],
                               d_bt[l*W +: W]);
                old = m_data[l*W +: W];
                if (d_valid) begin
                    m_data[l*W +: W]  = r[2*W-1:W];
                    m_taint[l*W +: W] = d_vt ? (r[W-1:0] | (r[2*W-1:W] ^ old)) : r[W-1:0];
                end else if (d_vt) begin
                    m_taint[l*W +: W] = m_taint[l*W +: W] | (r[2*W-1:W] ^ old);
                end
            end
            d_valid      = in_valid;
            d_vt         = in_valid_taint;
            d_op         = op;
            d_a          = a_data;
            d_at         = a_taint;
            d_b          = b_data;
            d_bt         = b_taint;
            d_addr       = wr_addr;
            d_addr_taint = wr_addr_taint;
        end
    end

    task automatic report_mismatch(input string what, input logic [RB-1:0] got,
                                   input logic [RB-1:0] exp);
        $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    // outputs are settled at the falling edge
    always @(negedge pos_clk) begin : compare
        logic [RB-1:0] exp_rd;
        if (!pos_arst) begin
            exp_rd = (rd_addr_taint != '0) ? '1 : m_rows[rd_addr];
            checks += 5;
            if (out_valid !== m_valid) report_mismatch("out_valid", RB'(out_valid), RB'(m_valid));
            if (res_data !== m_data) report_mismatch("res_data", res_data, m_data);
            if (res_taint !== m_taint) report_mismatch("res_taint", res_taint, m_taint);
            if (taint_count !== count_tainted_rows()) begin
                report_mismatch("taint_count", RB'(taint_count), RB'(count_tainted_rows()));
            end
            if (rd_taint !== exp_rd) report_mismatch("rd_taint", rd_taint, exp_rd);
        end
    end

    always @(posedge pos_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic drive(input logic v, input logic vt, input op_e o, input logic [RB-1:0] a,
            input logic [RB-1:0] at, input logic [RB-1:0] b, input logic [RB-1:0] bt,
            input logic [AB-1:0] wat);
        logic [31:0] r;
        @(posedge pos_clk);
        #2;
        r              = next_rand();
        in_valid       = v;
        in_valid_taint = vt;
        op             = o;
        a_data         = a;
        a_taint        = at;
        b_data         = b;
        b_taint        = bt;
        wr_addr        = r[0 +: AB];
        wr_addr_taint  = wat;
        rd_addr        = r[8 +: AB];
        // an occasional tainted read address
        rd_addr_taint  = (r[15:12] == 4'd0) ? r[16 +: AB] : '0;
    endtask

    task automatic run_ops(input int test, input int n);
        logic [31:0]   r;
        logic [RB-1:0] at;
        logic [RB-1:0] bt;
        logic          v;
        logic          vt;
        logic [AB-1:0] wat;
        op_e           o;
        for (int i = 0; i < n; i++) begin
            r   = next_rand();
            at  = '0;
            bt  = '0;
            v   = 1'b1;
            vt  = 1'b0;
            wat = '0;
            o   = op_e'(3'(i % 7));
            case (test)
                2: begin
                    o  = r[0] ? op_and : op_or;
                    v  = r[1] | r[2];
                    at = rand_bus() & rand_bus();
                    bt = rand_bus() & rand_bus();
                end
                3: begin
                    o  = r[0] ? op_add : op_sub;
                    at = bit_per_lane(r >> 8, 2);
                    bt = r[1] ? bit_per_lane(r >> 16, 2) : '0;
                end
                4: begin
                    o  = r[0] ? op_shl : op_shr;
                    at = rand_bus();
                    bt = r[1] ? '0 : bit_per_lane(r >> 8, SH);
                end
                5: begin
                    o   = op_e'(3'(r[15:8] % 8'd7));
                    at  = r[1] ? rand_bus() & rand_bus() : '0;
                    bt  = r[1] ? rand_bus() & rand_bus() : '0;
                    wat = (r[3:2] == 2'd0) ? r[16 +: AB] : '0;
                end
                6: begin
                    o  = op_e'(3'(r[15:8] % 8'd7));
                    v  = r[0];
                    vt = r[1];
                end
                default: ;
            endcase
            drive(v, vt, o, rand_bus(), at, rand_bus(), bt, wat);
        end
    endtask

    initial begin : main
        int err0;
        int chk0;
        int asrt;
        pos_arst       = 1'b1;
        in_valid       = 1'b0;
        in_valid_taint = 1'b0;
        op             = op_and;
        a_data         = '0;
        a_taint        = '0;
        b_data         = '0;
        b_taint        = '0;
        wr_addr        = '0;
        wr_addr_taint  = '0;
        rd_addr        = '0;
        rd_addr_taint  = '0;
        repeat (10) @(posedge pos_clk);
        #2;
        pos_arst = 1'b0;
        for (int t = 1; t <= 6; t++) begin
            err0 = errors;
            chk0 = checks;
            run_ops(t, 60);
            // idle cycles drain the three stage pipeline
            repeat (4) drive(1'b0, 1'b0, op_and, '0, '0, '0, '0, '0);
            $display("test %0d %s: %0d checks, %0d errors", t, test_names[t-1],
                     checks - chk0, errors - err0);
        end
        asrt = i_taint_alu_array.i_taint_alu_array_assert.fail_count;
        $display("totals: %0d checks, %0d errors, %0d assertion failures", checks, errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/taint_pkg.sv
rtl/operand_if.sv
rtl/operand_dispatch.sv
rtl/taint_lane.sv
rtl/taint_table.sv
rtl/taint_alu_array.sv
test/taint_alu_array_assert.sv
test/tb_taint_alu_array.sv

// File: run.sh
#!/bin/sh
# build and run the taint array testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_taint_alu_array -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
exit 1
